// File: build.f
logic/pattern_cfg_pkg.sv
logic/pattern_ctrl_pkg.sv
logic/sample_ram.sv
logic/sample_rate_divider.sv
logic/pattern_sequencer.sv
logic/pattern_buffer_ctrl.sv
logic/pattern_gen_top.sv
verif/pattern_seq_sva.sv
verif/pattern_gen_tb.sv

// File: Bender.yml
package:
  name: pattern_gen

sources:
  # Packages ahead of the modules that import them
  - logic/pattern_cfg_pkg.sv
  - logic/pattern_ctrl_pkg.sv
  - logic/sample_ram.sv
  - logic/sample_rate_divider.sv
  - logic/pattern_sequencer.sv
  - logic/pattern_buffer_ctrl.sv
  - logic/pattern_gen_top.sv
  - target: test
    files:
      - verif/pattern_seq_sva.sv
      - verif/pattern_gen_tb.sv

// File: verif/pattern_gen_tb.sv
// Pattern generator testbench
// Directed tests with output looped back to input and a software-side model
`default_nettype none

module pattern_gen_tb;

   import pattern_cfg_pkg::*;
   import pattern_ctrl_pkg::*;

   localparam int NUM_SIG     = 14;
   localparam int NUM_SAMP    = 16;
   localparam int RUN_TIMEOUT = 2000;

   logic               axi_clk;
   logic               axi_resetn;
   logic               run;
   logic [NUM_SIG-1:0] write_channel;
   logic               write_channel_wr_strobe;
   logic               read_channel_rd_strobe;
   reg_word_t          n_samples;
   ctrl_t              control;
   div_t               rate_div;
   logic [NUM_SIG-1:0] read_channel;
   reg_word_t          sample_count;
   reg_word_t          write_buffer_len;
   reg_word_t          next_read_sample;
   reg_word_t          wave_ptr;
   status_t            status;
   logic [NUM_SIG-1:0] output_signals;
   logic [NUM_SIG-1:0] input_signals;

   // Model of what software wrote and what the loopback must have captured
   logic [NUM_SIG-1:0] pat_model [NUM_SAMP];
   logic [NUM_SIG-1:0] cap_model [NUM_SAMP];
   bit                 cap_known [NUM_SAMP];
   logic [31:0]        rng_state = 32'hb554;
   int                 checks    = 0;
   int                 errors    = 0;

   // Loopback
   assign input_signals = output_signals;

   pattern_gen_top #(.NUM_SIG(NUM_SIG), .NUM_SAMP(NUM_SAMP)) DUT (
      .axi_clk, .axi_resetn, .run, .write_channel, .write_channel_wr_strobe,
      .read_channel_rd_strobe, .n_samples, .control, .rate_div, .read_channel,
      .sample_count, .write_buffer_len, .next_read_sample, .wave_ptr, .status,
      .output_signals, .input_signals
   );

   initial begin
      axi_clk = 1'b0;
      forever #5 axi_clk = ~axi_clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int err_before);
      $display("test %s finished with %0d error(s)", name, errors - err_before);
   endtask

   // One-cycle strobes, driven on the falling edge
   task automatic write_word(input logic [NUM_SIG-1:0] word);
      @(negedge axi_clk);
      write_channel           = word;
      write_channel_wr_strobe = 1'b1;
      @(negedge axi_clk);
      write_channel_wr_strobe = 1'b0;
   endtask

   task automatic read_word();
      @(negedge axi_clk);
      read_channel_rd_strobe = 1'b1;
      @(negedge axi_clk);
      read_channel_rd_strobe = 1'b0;
   endtask

   task automatic start_run(input reg_word_t n, input ctrl_t ctrl, input div_t div);
      @(negedge axi_clk);
      n_samples = n;
      control   = ctrl;
      rate_div  = div;
      run       = 1'b1;
      @(negedge axi_clk);
      run = 1'b0;
   endtask

   // Follows a run until idle, checking each played word against the pattern
   // Optionally clears loop once clear_at samples have been seen
   task automatic observe_run(input int period, input int clear_at, output int played,
                              output logic [NUM_SIG-1:0] last_word);
      reg_word_t last_count;
      int        cycles;
      int        k;
      bit        idle;
      played     = 0;
      last_word  = '0;
      last_count = sample_count;
      idle       = 1'b0;
      cycles     = 0;
      while (!idle && cycles < RUN_TIMEOUT) begin
         @(negedge axi_clk);
         cycles++;
         if (sample_count != last_count) begin
            k = played % period;
            check_value("output_signals", output_signals, pat_model[k]);
            // Pointer has moved on to the next entry
            if (k + 1 < period) begin
               check_value("wave_ptr", wave_ptr, k + 1);
            end
            // Capture sees the word shown before this tick
            cap_model[k] = (played == 0) ? '0 : pat_model[(played - 1) % period];
            cap_known[k] = 1'b1;
            last_word    = output_signals;
            last_count   = sample_count;
            played++;
            if (clear_at > 0 && played == clear_at) begin
               control = '0;
            end
         end
         if (status == '0) begin
            idle = 1'b1;
         end
      end
      if (!idle) begin
         $display("ERROR: sequencer did not return to idle within %0d cycles", RUN_TIMEOUT);
         errors++;
      end
   endtask

   task automatic test_reset();
      int err0;
      err0 = errors;
      check_value("output_signals", output_signals, 0);
      check_value("status", status, 0);
      check_value("sample_count", sample_count, 0);
      check_value("write_buffer_len", write_buffer_len, 0);
      check_value("next_read_sample", next_read_sample, 0);
      check_value("wave_ptr", wave_ptr, 0);
      check_value("read_channel", read_channel, 0);
      end_test("reset", err0);
   endtask

   task automatic test_fill();
      int                 err0;
      logic [NUM_SIG-1:0] word;
      err0 = errors;
      for (int i = 0; i < 20; i++) begin
         rng_state = xorshift32(rng_state);
         word      = rng_state[NUM_SIG-1:0];
         if (i < NUM_SAMP) begin
            pat_model[i] = word;
         end
         write_word(word);
         // Length saturates once the store is full
         check_value("write_buffer_len", write_buffer_len, (i < NUM_SAMP) ? i + 1 : NUM_SAMP);
      end
      end_test("fill", err0);
   endtask

   task automatic test_one_shot();
      int                 err0;
      int                 played;
      logic [NUM_SIG-1:0] last;
      reg_word_t          count0;
      err0   = errors;
      count0 = sample_count;
      start_run(5, '0, 3);
      observe_run(5, 0, played, last);
      check_value("played samples", played, 5);
      check_value("sample_count delta", sample_count - count0, 5);
      check_value("status", status, 0);
      check_value("write_buffer_len", write_buffer_len, 0);
      check_value("output_signals", output_signals, 0);
      end_test("one_shot", err0);
   endtask

   task automatic test_readback();
      int err0;
      int cursor;
      err0 = errors;
      check_value("read_channel", read_channel, cap_model[0]);
      check_value("next_read_sample", next_read_sample, 1);
      cursor = 1;
      // Walk past the end so the saturated cursor is exercised too
      for (int i = 0; i < NUM_SAMP + 1; i++) begin
         read_word();
         if (cursor >= NUM_SAMP) begin
            check_value("read_channel", read_channel, 0);
         end else if (cap_known[cursor]) begin
            check_value("read_channel", read_channel, cap_model[cursor]);
         end
         if (cursor < NUM_SAMP) begin
            cursor++;
         end
         check_value("next_read_sample", next_read_sample, cursor);
      end
      end_test("readback", err0);
   endtask

   task automatic test_clamp();
      int                 err0;
      int                 played;
      logic [NUM_SIG-1:0] last;
      reg_word_t          count0;
      err0   = errors;
      // Oversized request plays the whole store
      count0 = sample_count;
      start_run(100, '0, 1);
      observe_run(NUM_SAMP, 0, played, last);
      check_value("sample_count delta", sample_count - count0, NUM_SAMP);
      // Zero request plays one sample
      count0 = sample_count;
      start_run(0, '0, 1);
      observe_run(1, 0, played, last);
      check_value("sample_count delta", sample_count - count0, 1);
      end_test("clamp", err0);
   endtask

   task automatic test_loop();
      int                 err0;
      int                 played;
      logic [NUM_SIG-1:0] last;
      reg_word_t          count0;
      ctrl_t              ctrl;
      err0            = errors;
      count0          = sample_count;
      ctrl            = '0;
      ctrl[CTRL_LOOP] = 1'b1;
      start_run(4, ctrl, 2);
      // Three full wraps, then one more pass after loop is cleared
      observe_run(4, 12, played, last);
      check_value("sample_count delta", sample_count - count0, 16);
      check_value("last output word", last, pat_model[3]);
      check_value("status", status, 0);
      end_test("loop", err0);
   endtask

   initial begin
      axi_resetn              = 1'b0;
      run                     = 1'b0;
      write_channel           = '0;
      write_channel_wr_strobe = 1'b0;
      read_channel_rd_strobe  = 1'b0;
      n_samples               = '0;
      control                 = '0;
      rate_div                = '0;
      repeat (4) @(posedge axi_clk);
      @(negedge axi_clk);
      axi_resetn = 1'b1;
      test_reset();
      test_fill();
      test_one_shot();
      test_readback();
      test_clamp();
      test_loop();
      // Fold in failures from the bound sequencer checker
      errors += DUT.u_sequencer.u_seq_sva.fail_count;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule : pattern_gen_tb

`default_nettype wire

// File: verif/pattern_seq_sva.sv
// Sequencer assertions
// Bound into pattern_sequencer, covers pin idling, pointer range and DONE timing
`default_nettype none

module pattern_seq_sva #(
   parameter int NUM_SIG  = 14,
   parameter int NUM_SAMP = 128
) (
   input wire logic                         axi_clk,
   input wire logic                         axi_resetn,
   input wire pattern_ctrl_pkg::seq_state_t state,
   input wire logic                         triggered,
   input wire logic [NUM_SIG-1:0]           output_signals,
   input wire pattern_cfg_pkg::reg_word_t   wave_ptr
);

   import pattern_ctrl_pkg::*;

   // Failed assertion count
   int fail_count = 0;

   // Pins stay quiet whenever no playback is active
   out_idle_zero: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
      (state != SEQ_RUN) |-> (output_signals == '0))
      else begin
         $error("output_signals nonzero outside SEQ_RUN");
         fail_count++;
      end

   // Pointer never leaves the store
   ptr_in_range: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
      wave_ptr < NUM_SAMP)
      else begin
         $error("wave_ptr out of range");
         fail_count++;
      end

   // DONE is a single-cycle state
   done_one_cycle: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
      (state == SEQ_DONE) |=> (state != SEQ_DONE))
      else begin
         $error("SEQ_DONE held for more than one cycle");
         fail_count++;
      end

   // Run latch drops with DONE
   trig_cleared: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
      (state == SEQ_DONE) |=> !triggered)
      else begin
         $error("triggered still set after SEQ_DONE");
         fail_count++;
      end

endmodule : pattern_seq_sva

bind pattern_sequencer pattern_seq_sva #(.NUM_SIG(NUM_SIG), .NUM_SAMP(NUM_SAMP)) u_seq_sva (
   .axi_clk, .axi_resetn, .state, .triggered, .output_signals, .wave_ptr
);

`default_nettype wire

// File: logic/pattern_gen_top.sv
// Arbitrary digital pattern generator with simultaneous capture
// Divider, sequencer, buffer controller and the two sample stores
`default_nettype none

module pattern_gen_top #(
   parameter int NUM_SIG  = 14,
   parameter int NUM_SAMP = 128
) (
   input  wire logic                       axi_clk,
   input  wire logic                       axi_resetn,
   input  wire logic                       run,
   input  wire logic [NUM_SIG-1:0]         write_channel,
   input  wire logic                       write_channel_wr_strobe,
   input  wire logic                       read_channel_rd_strobe,
   input  wire pattern_cfg_pkg::reg_word_t n_samples,
   input  wire pattern_ctrl_pkg::ctrl_t    control,
   input  wire pattern_cfg_pkg::div_t      rate_div,
   output logic [NUM_SIG-1:0]              read_channel,
   output pattern_cfg_pkg::reg_word_t      sample_count,
   output pattern_cfg_pkg::reg_word_t      write_buffer_len,
   output pattern_cfg_pkg::reg_word_t      next_read_sample,
   output pattern_cfg_pkg::reg_word_t      wave_ptr,
   output pattern_ctrl_pkg::status_t       status,
   output logic [NUM_SIG-1:0]              output_signals,
   input  wire logic [NUM_SIG-1:0]         input_signals
);

   import pattern_ctrl_pkg::*;

   localparam int AW = (NUM_SAMP > 1) ? $clog2(NUM_SAMP) : 1;

   logic               sample_tick;
   logic               loop;
   seq_state_t         state;
   // Pattern store
   logic               pat_we;
   logic [AW-1:0]      pat_waddr;
   logic [NUM_SIG-1:0] pat_wdata;
   logic [AW-1:0]      pat_raddr;
   logic [NUM_SIG-1:0] pat_rdata;
   // Capture store
   logic               cap_we;
   logic [AW-1:0]      cap_waddr;
   logic [NUM_SIG-1:0] cap_wdata;
   logic [AW-1:0]      cap_raddr;
   logic [NUM_SIG-1:0] cap_rdata;

   assign loop = control[CTRL_LOOP];

   sample_rate_divider u_divider (
      .axi_clk, .axi_resetn, .rate_div, .sample_tick
   );

   pattern_sequencer #(.NUM_SIG(NUM_SIG), .NUM_SAMP(NUM_SAMP)) u_sequencer (
      .axi_clk, .axi_resetn, .run, .loop, .n_samples, .sample_tick,
      .pat_raddr, .pat_rdata, .cap_we, .cap_waddr, .cap_wdata,
      .input_signals, .output_signals, .state, .status, .sample_count, .wave_ptr
   );

   pattern_buffer_ctrl #(.NUM_SIG(NUM_SIG), .NUM_SAMP(NUM_SAMP)) u_buffer_ctrl (
      .axi_clk, .axi_resetn, .state, .write_channel, .write_channel_wr_strobe,
      .read_channel_rd_strobe, .pat_we, .pat_waddr, .pat_wdata, .cap_raddr,
      .cap_rdata, .read_channel, .write_buffer_len, .next_read_sample
   );

   // Written by software, read by the sequencer
   sample_ram #(.NUM_SIG(NUM_SIG), .NUM_SAMP(NUM_SAMP)) pattern_store (
      .axi_clk, .we(pat_we), .waddr(pat_waddr), .wdata(pat_wdata),
      .raddr(pat_raddr), .rdata(pat_rdata)
   );

   // Written by the sequencer, read back by software
   sample_ram #(.NUM_SIG(NUM_SIG), .NUM_SAMP(NUM_SAMP)) capture_store (
      .axi_clk, .we(cap_we), .waddr(cap_waddr), .wdata(cap_wdata),
      .raddr(cap_raddr), .rdata(cap_rdata)
   );

endmodule : pattern_gen_top

`default_nettype wire

// File: logic/pattern_buffer_ctrl.sv
// Pattern buffer controller
// Fills the pattern store from register writes and walks the capture store
// on register reads, both rearmed when a run completes
`default_nettype none

module pattern_buffer_ctrl #(
   parameter int NUM_SIG  = 14,
   parameter int NUM_SAMP = 128
) (
   input  wire logic                                      axi_clk,
   input  wire logic                                      axi_resetn,
   input  wire pattern_ctrl_pkg::seq_state_t              state,
   input  wire logic [NUM_SIG-1:0]                        write_channel,
   input  wire logic                                      write_channel_wr_strobe,
   input  wire logic                                      read_channel_rd_strobe,
   output logic                                           pat_we,
   output logic [((NUM_SAMP > 1) ? $clog2(NUM_SAMP) : 1)-1:0] pat_waddr,
   output logic [NUM_SIG-1:0]                             pat_wdata,
   output logic [((NUM_SAMP > 1) ? $clog2(NUM_SAMP) : 1)-1:0] cap_raddr,
   input  wire logic [NUM_SIG-1:0]                        cap_rdata,
   output logic [NUM_SIG-1:0]                             read_channel,
   output pattern_cfg_pkg::reg_word_t                     write_buffer_len,
   output pattern_cfg_pkg::reg_word_t                     next_read_sample
);

   import pattern_ctrl_pkg::*;

   localparam int AW = (NUM_SAMP > 1) ? $clog2(NUM_SAMP) : 1;

   // Write accepted only while idle and with room left
   logic wr_ok;
   // Cursor still points inside the capture store
   logic rd_valid;

   assign wr_ok    = write_channel_wr_strobe && (state == SEQ_IDLE) &&
                     (write_buffer_len < NUM_SAMP);
   assign rd_valid = (next_read_sample < NUM_SAMP);

   // Pattern store write port, entry index is the current fill length
   assign pat_we    = wr_ok;
   assign pat_waddr = write_buffer_len[AW-1:0];
   assign pat_wdata = write_channel;

   // DONE preloads entry 0, otherwise the cursor selects the entry
   assign cap_raddr = (state == SEQ_DONE) ? '0 : next_read_sample[AW-1:0];

   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         write_buffer_len <= '0;
         next_read_sample <= '0;
         read_channel     <= '0;
      end else if (state == SEQ_DONE) begin
         // Fresh capture available and pattern store free for refill
         write_buffer_len <= '0;
         next_read_sample <= 32'd1;
         read_channel     <= cap_rdata;
      end else begin
         if (wr_ok) begin
            write_buffer_len <= write_buffer_len + 32'd1;
         end
         if (read_channel_rd_strobe) begin
            // Past the end reads return zero
            read_channel <= rd_valid ? cap_rdata : '0;
            // Cursor saturates at NUM_SAMP
            if (rd_valid) begin
               next_read_sample <= next_read_sample + 32'd1;
            end
         end
      end
   end

endmodule : pattern_buffer_ctrl

`default_nettype wire

// File: logic/pattern_sequencer.sv
// Pattern sequencer
// Latches run, steps the playback FSM on sample ticks, drives the pattern
// pins, writes captured inputs and counts samples
`default_nettype none

module pattern_sequencer #(
   parameter int NUM_SIG  = 14,
   parameter int NUM_SAMP = 128
) (
   input  wire logic                                      axi_clk,
   input  wire logic                                      axi_resetn,
   input  wire logic                                      run,
   input  wire logic                                      loop,
   input  wire pattern_cfg_pkg::reg_word_t                n_samples,
   input  wire logic                                      sample_tick,
   output logic [((NUM_SAMP > 1) ? $clog2(NUM_SAMP) : 1)-1:0] pat_raddr,
   input  wire logic [NUM_SIG-1:0]                        pat_rdata,
   output logic                                           cap_we,
   output logic [((NUM_SAMP > 1) ? $clog2(NUM_SAMP) : 1)-1:0] cap_waddr,
   output logic [NUM_SIG-1:0]                             cap_wdata,
   input  wire logic [NUM_SIG-1:0]                        input_signals,
   output logic [NUM_SIG-1:0]                             output_signals,
   output pattern_ctrl_pkg::seq_state_t                   state,
   output pattern_ctrl_pkg::status_t                      status,
   output pattern_cfg_pkg::reg_word_t                     sample_count,
   output pattern_cfg_pkg::reg_word_t                     wave_ptr
);

   import pattern_cfg_pkg::*;
   import pattern_ctrl_pkg::*;

   localparam int AW = (NUM_SAMP > 1) ? $clog2(NUM_SAMP) : 1;

   logic      triggered;
   // Last sample played, waiting one more tick before DONE
   logic      drain;
   reg_word_t n_eff;
   reg_word_t last_idx;
   logic      at_last;
   // Tick on which a sample is played and captured
   logic      play_tick;

   // Clamp requested count to 1..NUM_SAMP
   always_comb begin
      if (n_samples == '0) begin
         n_eff = reg_word_t'(1);
      end else if (n_samples > reg_word_t'(NUM_SAMP)) begin
         n_eff = reg_word_t'(NUM_SAMP);
      end else begin
         n_eff = n_samples;
      end
      last_idx = n_eff - 1'b1;
   end

   assign at_last   = (wave_ptr >= last_idx);
   assign play_tick = sample_tick && (state == SEQ_RUN) && !drain;

   // Store ports follow the wave pointer
   assign pat_raddr = wave_ptr[AW-1:0];
   assign cap_waddr = wave_ptr[AW-1:0];
   assign cap_we    = play_tick;
   assign cap_wdata = input_signals;

   assign status = {triggered, state};

   // Run latch, cleared by DONE
   // DONE wins so the flag is low once the sequencer is back in IDLE
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         triggered <= 1'b0;
      end else if (state == SEQ_DONE) begin
         triggered <= 1'b0;
      end else if (run) begin
         triggered <= 1'b1;
      end
   end

   // Playback FSM
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         state <= SEQ_IDLE;
      end else begin
         case (state)
            SEQ_IDLE: if (triggered && sample_tick) state <= SEQ_RUN;
            SEQ_RUN:  if (sample_tick && drain) state <= SEQ_DONE;
            SEQ_DONE: state <= SEQ_IDLE;
            default:  state <= SEQ_IDLE;
         endcase
      end
   end

   // Pointer, pins and sample counter
   // The last word stays on the pins for a full sample period, then
   // the drain tick clears them as the FSM leaves RUN
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         wave_ptr       <= '0;
         drain          <= 1'b0;
         output_signals <= '0;
         sample_count   <= '0;
      end else if (play_tick) begin
         output_signals <= pat_rdata;
         sample_count   <= sample_count + 1'b1;
         if (at_last) begin
            // Wrap in loop mode, otherwise finish after one more tick
            wave_ptr <= '0;
            drain    <= !loop;
         end else begin
            wave_ptr <= wave_ptr + 1'b1;
         end
      end else if (state != SEQ_RUN) begin
         wave_ptr       <= '0;
         drain          <= 1'b0;
         output_signals <= '0;
      end else if (sample_tick) begin
         // Drain tick
         drain          <= 1'b0;
         output_signals <= '0;
      end
   end

endmodule : pattern_sequencer

`default_nettype wire

// File: logic/sample_rate_divider.sv
// Sample-rate divider
// Free-running counter that issues one tick every rate_div+1 clocks
`default_nettype none

module sample_rate_divider (
   input  wire logic                  axi_clk,
   input  wire logic                  axi_resetn,
   input  wire pattern_cfg_pkg::div_t rate_div,
   output logic                       sample_tick
);

   import pattern_cfg_pkg::*;

   // Position within the current sample period
   div_t cnt;

   // Counter runs 0..rate_div then wraps
   // Tick is registered so it stays low while in reset
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         cnt         <= '0;
         sample_tick <= 1'b0;
      end else begin
         // Greater-or-equal also recovers when rate_div shrinks mid-period
         if (cnt >= rate_div) begin
            cnt         <= '0;
            sample_tick <= 1'b1;
         end else begin
            cnt         <= cnt + 1'b1;
            sample_tick <= 1'b0;
         end
      end
   end

endmodule : sample_rate_divider

`default_nettype wire

// File: logic/sample_ram.sv
// Sample store
// NUM_SAMP words of NUM_SIG bits, clocked write and combinational read
`default_nettype none

module sample_ram #(
   parameter int NUM_SIG  = 14,
   parameter int NUM_SAMP = 128
) (
   input  wire logic                                      axi_clk,
   input  wire logic                                      we,
   input  wire logic [((NUM_SAMP > 1) ? $clog2(NUM_SAMP) : 1)-1:0] waddr,
   input  wire logic [NUM_SIG-1:0]                        wdata,
   input  wire logic [((NUM_SAMP > 1) ? $clog2(NUM_SAMP) : 1)-1:0] raddr,
   output logic      [NUM_SIG-1:0]                        rdata
);

   // Index width
   localparam int AW = (NUM_SAMP > 1) ? $clog2(NUM_SAMP) : 1;

   // Storage array
   // Contents after power-up are undefined until written
   logic [NUM_SIG-1:0] mem [NUM_SAMP];

   // Write port
   always_ff @(posedge axi_clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Read port, same-cycle data
   // Index is always AW bits wide, callers keep it below NUM_SAMP
   always_comb begin
      rdata = mem[raddr[AW-1:0]];
   end

endmodule : sample_ram

`default_nettype wire

// File: logic/pattern_ctrl_pkg.sv
// Pattern generator control definitions
// Sequencer states, control register layout and status word
`default_nettype none

package pattern_ctrl_pkg;

   // Control register as written by software
   typedef logic [7:0] ctrl_t;

   // Bit position of the loop enable in ctrl_t
   localparam logic [2:0] CTRL_LOOP = 3'd0;

   // Sequencer states
   // DONE is a single-cycle state that rearms the buffers
   typedef enum logic [1:0] {
      SEQ_IDLE = 2'd0,
      SEQ_RUN  = 2'd1,
      SEQ_DONE = 2'd2
   } seq_state_t;

   // Status word, triggered flag above the two state bits
   typedef logic [2:0] status_t;

endpackage : pattern_ctrl_pkg

`default_nettype wire

// File: logic/pattern_cfg_pkg.sv
// Pattern generator sizing types
// Word and divisor widths shared by the register block, buffers and counters
`default_nettype none

package pattern_cfg_pkg;

   // Width of one software-visible register
   localparam int REG_W = 32;

   // Width of the sample-rate divisor register
   localparam int DIV_W = 16;

   // Register word
   // Used for sample counts, buffer fill length, read cursor and wave pointer
   typedef logic [REG_W-1:0] reg_word_t;

   // Sample-rate divisor
   // A value of N gives one sample tick every N+1 clocks
   typedef logic [DIV_W-1:0] div_t;

endpackage : pattern_cfg_pkg

`default_nettype wire
